/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_ntt_masked_top
FILELIST  = ntt_masked_intt.f
BIN       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

/* mask_prng.sv */
// Mask generator
module mask_prng #(
    parameter int unsigned MOD_Q     = ntt_masked_pkg::MLDSA_Q,
    parameter logic [31:0] MASK_SEED = 32'h1
) (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize_i,
    output ntt_masked_pkg::mask_rnd_t rnd_o
);
    import ntt_masked_pkg::*;

    localparam coeff_t Q_C = coeff_t'(MOD_Q);
    // x^23 + x^18 + 1, right-shift Galois form
    localparam coeff_t TAPS = 23'h42_0000;

    coeff_t lfsr_q [N_MASKS];

    // Byte-rotated slice of the seed, never zero
    function automatic coeff_t lfsr_seed(int unsigned idx);
        logic [63:0] dbl;
        coeff_t      seed;
        dbl  = {MASK_SEED, MASK_SEED} >> (8 * idx);
        seed = dbl[COEFF_W-1:0];
        if (seed == '0) begin
            seed = coeff_t'(idx + 1);
        end
        return seed;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < N_MASKS; i++) begin
                lfsr_q[i] <= lfsr_seed(i);
            end
        end
        else if (zeroize_i) begin
            for (int i = 0; i < N_MASKS; i++) begin
                lfsr_q[i] <= lfsr_seed(i);
            end
        end
        else begin
            for (int i = 0; i < N_MASKS; i++) begin
                lfsr_q[i] <= lfsr_q[i][0] ? ((lfsr_q[i] >> 1) ^ TAPS) : (lfsr_q[i] >> 1);
            end
        end
    end

    // LFSR state is below 2^23 < 2Q, one subtraction is enough
    always_comb begin
        for (int i = 0; i < N_MASKS; i++) begin
            rnd_o[i] = (lfsr_q[i] >= Q_C) ? lfsr_q[i] - Q_C : lfsr_q[i];
        end
    end

endmodule

/* masked_gs_butterfly.sv */
// Masked Gentleman-Sande butterfly
module masked_gs_butterfly #(
    parameter int unsigned MOD_Q = ntt_masked_pkg::MLDSA_Q
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize_i,
    input  ntt_masked_pkg::masked_coeff_t opu_i,
    input  ntt_masked_pkg::masked_coeff_t opv_i,
    input  ntt_masked_pkg::coeff_t        opw_i,
    input  ntt_masked_pkg::coeff_t        rnd_u_i,
    input  ntt_masked_pkg::coeff_t        rnd_v_i,
    output ntt_masked_pkg::masked_coeff_t u_o,
    output ntt_masked_pkg::masked_coeff_t v_o
);
    import ntt_masked_pkg::*;

    localparam coeff_t Q_C = coeff_t'(MOD_Q);

    masked_coeff_t u_ref;
    masked_coeff_t v_ref;
    masked_coeff_t sum_d;
    masked_coeff_t diff_d;
    masked_coeff_t sum_q;
    masked_coeff_t diff_q;
    masked_coeff_t sum_dly1_q;
    masked_coeff_t sum_dly2_q;
    coeff_t        w_q;
    coeff_t        prod_s0;
    coeff_t        prod_s1;

    always_comb begin
        // Refresh, mask goes into share0 and out of share1
        u_ref.share0 = add_mod(opu_i.share0, rnd_u_i, Q_C);
        u_ref.share1 = sub_mod(opu_i.share1, rnd_u_i, Q_C);
        v_ref.share0 = add_mod(opv_i.share0, rnd_v_i, Q_C);
        v_ref.share1 = sub_mod(opv_i.share1, rnd_v_i, Q_C);

        // Share-wise GS sum and difference
        sum_d.share0  = add_mod(u_ref.share0, v_ref.share0, Q_C);
        sum_d.share1  = add_mod(u_ref.share1, v_ref.share1, Q_C);
        diff_d.share0 = sub_mod(u_ref.share0, v_ref.share0, Q_C);
        diff_d.share1 = sub_mod(u_ref.share1, v_ref.share1, Q_C);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum_q      <= '0;
            diff_q     <= '0;
            w_q        <= '0;
            sum_dly1_q <= '0;
            sum_dly2_q <= '0;
        end
        else if (zeroize_i) begin
            sum_q      <= '0;
            diff_q     <= '0;
            w_q        <= '0;
            sum_dly1_q <= '0;
            sum_dly2_q <= '0;
        end
        else begin
            sum_q      <= sum_d;
            diff_q     <= diff_d;
            w_q        <= opw_i;
            // Match the two multiplier stages
            sum_dly1_q <= sum_q;
            sum_dly2_q <= sum_dly1_q;
        end
    end

    // Twiddle is public, so each share is scaled on its own
    mod_mult #(
        .MOD_Q(MOD_Q)
    ) u_mult_s0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize_i(zeroize_i),
        .a_i      (diff_q.share0),
        .b_i      (w_q),
        .p_o      (prod_s0)
    );

    mod_mult #(
        .MOD_Q(MOD_Q)
    ) u_mult_s1 (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize_i(zeroize_i),
        .a_i      (diff_q.share1),
        .b_i      (w_q),
        .p_o      (prod_s1)
    );

    assign u_o = sum_dly2_q;
    assign v_o = '{share0: prod_s0, share1: prod_s1};

endmodule

/* mod_mult.sv */
// Pipelined modular multiplier
module mod_mult #(
    parameter int unsigned MOD_Q = ntt_masked_pkg::MLDSA_Q
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize_i,
    input  ntt_masked_pkg::coeff_t a_i,
    input  ntt_masked_pkg::coeff_t b_i,
    output ntt_masked_pkg::coeff_t p_o
);
    import ntt_masked_pkg::*;

    localparam coeff_prod_t Q_P = coeff_prod_t'(MOD_Q);

    // Full 46-bit product, stage 1
    coeff_prod_t prod_q;
    coeff_prod_t prod_red;

    always_comb begin
        // Remainder is always below Q, so it fits a coefficient
        prod_red = prod_q % Q_P;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
            p_o    <= '0;
        end
        else if (zeroize_i) begin
            prod_q <= '0;
            p_o    <= '0;
        end
        else begin
            prod_q <= coeff_prod_t'(a_i) * coeff_prod_t'(b_i);
            p_o    <= prod_red[COEFF_W-1:0];
        end
    end

endmodule

/* ntt_masked_butterfly1x2.sv */
// Masked INTT butterfly stage
module ntt_masked_butterfly1x2 #(
    parameter int unsigned MOD_Q = ntt_masked_pkg::MLDSA_Q
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize_i,
    input  logic                          valid_i,
    input  ntt_masked_pkg::masked_bf_in_t uvw_i,
    input  ntt_masked_pkg::mask_rnd_t     rnd_i,
    output logic                          valid_o,
    output ntt_masked_pkg::bf_uv_out_t    uv_o
);
    import ntt_masked_pkg::*;

    // Three butterfly cycles plus the unmask register
    localparam int unsigned LATENCY = 4;

    logic [LATENCY-1:0] valid_sr_q;

    masked_coeff_t bf_u_in  [2];
    masked_coeff_t bf_v_in  [2];
    coeff_t        bf_w_in  [2];
    masked_coeff_t bf_u_out [2];
    masked_coeff_t bf_v_out [2];
    coeff_t        half_u   [2];
    coeff_t        half_v   [2];

    assign bf_u_in[0] = uvw_i.u00;
    assign bf_v_in[0] = uvw_i.v00;
    assign bf_w_in[0] = uvw_i.w00;
    assign bf_u_in[1] = uvw_i.u01;
    assign bf_v_in[1] = uvw_i.v01;
    assign bf_w_in[1] = uvw_i.w01;

    for (genvar g = 0; g < 2; g++) begin : g_bf
        // Butterfly g takes masks 2g and 2g+1
        masked_gs_butterfly #(
            .MOD_Q(MOD_Q)
        ) u_bf (
            .clk      (clk),
            .reset_n  (reset_n),
            .zeroize_i(zeroize_i),
            .opu_i    (bf_u_in[g]),
            .opv_i    (bf_v_in[g]),
            .opw_i    (bf_w_in[g]),
            .rnd_u_i  (rnd_i[2*g]),
            .rnd_v_i  (rnd_i[2*g+1]),
            .u_o      (bf_u_out[g]),
            .v_o      (bf_v_out[g])
        );

        share_unmask_div2 #(
            .MOD_Q(MOD_Q)
        ) u_unmask_u (
            .clk      (clk),
            .reset_n  (reset_n),
            .zeroize_i(zeroize_i),
            .x_i      (bf_u_out[g]),
            .res_o    (half_u[g])
        );

        share_unmask_div2 #(
            .MOD_Q(MOD_Q)
        ) u_unmask_v (
            .clk      (clk),
            .reset_n  (reset_n),
            .zeroize_i(zeroize_i),
            .x_i      (bf_v_out[g]),
            .res_o    (half_v[g])
        );
    end

    assign uv_o = '{u20: half_u[0], u21: half_v[0], v20: half_u[1], v21: half_v[1]};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_sr_q <= '0;
        end
        else if (zeroize_i) begin
            valid_sr_q <= '0;
        end
        else begin
            valid_sr_q <= {valid_sr_q[LATENCY-2:0], valid_i};
        end
    end

    assign valid_o = valid_sr_q[LATENCY-1];

endmodule

/* ntt_masked_intt.f */
ntt_masked_pkg.sv
mod_mult.sv
masked_gs_butterfly.sv
share_unmask_div2.sv
mask_prng.sv
ntt_masked_butterfly1x2.sv
ntt_masked_top.sv
tb_ntt_masked_top.sv

/* ntt_masked_pkg.sv */
// Masked INTT shared types
package ntt_masked_pkg;

    // ML-DSA prime modulus
    localparam int unsigned MLDSA_Q = 32'd8380417;
    localparam int unsigned COEFF_W = 23;
    localparam int unsigned N_MASKS = 4;

    typedef logic [COEFF_W-1:0]   coeff_t;
    typedef logic [2*COEFF_W-1:0] coeff_prod_t;

    // Two-share arithmetic masking, value = share0 + share1 mod Q
    typedef struct packed {
        coeff_t share0;
        coeff_t share1;
    } masked_coeff_t;

    typedef coeff_t [N_MASKS-1:0] mask_rnd_t;

    typedef struct packed {
        masked_coeff_t u00;
        masked_coeff_t v00;
        coeff_t        w00;
        masked_coeff_t u01;
        masked_coeff_t v01;
        coeff_t        w01;
    } masked_bf_in_t;

    typedef struct packed {
        coeff_t u20;
        coeff_t u21;
        coeff_t v20;
        coeff_t v21;
    } bf_uv_out_t;

    // Both operands must already lie below q
    function automatic coeff_t add_mod(coeff_t a, coeff_t b, coeff_t q);
        logic [COEFF_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= {1'b0, q}) begin
            sum = sum - {1'b0, q};
        end
        return sum[COEFF_W-1:0];
    endfunction

    function automatic coeff_t sub_mod(coeff_t a, coeff_t b, coeff_t q);
        logic [COEFF_W:0] diff;
        diff = {1'b0, a} - {1'b0, b};
        // Borrow out means a < b, wrap back into range
        if (diff[COEFF_W]) begin
            diff = diff + {1'b0, q};
        end
        return diff[COEFF_W-1:0];
    endfunction

endpackage

/* ntt_masked_top.sv */
// Masked INTT stage top
module ntt_masked_top #(
    parameter int unsigned MOD_Q     = ntt_masked_pkg::MLDSA_Q,
    parameter logic [31:0] MASK_SEED = 32'h5a3c_96e1
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize_i,
    input  logic                          valid_i,
    input  ntt_masked_pkg::masked_bf_in_t uvw_i,
    output logic                          valid_o,
    output ntt_masked_pkg::bf_uv_out_t    uv_o
);
    import ntt_masked_pkg::*;

    // Fresh masks, one set per cycle
    mask_rnd_t rnd;

    mask_prng #(
        .MOD_Q    (MOD_Q),
        .MASK_SEED(MASK_SEED)
    ) u_mask_prng (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize_i(zeroize_i),
        .rnd_o    (rnd)
    );

    ntt_masked_butterfly1x2 #(
        .MOD_Q(MOD_Q)
    ) u_bf1x2 (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize_i(zeroize_i),
        .valid_i  (valid_i),
        .uvw_i    (uvw_i),
        .rnd_i    (rnd),
        .valid_o  (valid_o),
        .uv_o     (uv_o)
    );

endmodule

/* share_unmask_div2.sv */
// Share recombine and halve
module share_unmask_div2 #(
    parameter int unsigned MOD_Q = ntt_masked_pkg::MLDSA_Q
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize_i,
    input  ntt_masked_pkg::masked_coeff_t x_i,
    output ntt_masked_pkg::coeff_t        res_o
);
    import ntt_masked_pkg::*;

    localparam coeff_t Q_C = coeff_t'(MOD_Q);

    coeff_t           sum;
    logic [COEFF_W:0] sum_odd;
    coeff_t           half;

    always_comb begin
        sum     = add_mod(x_i.share0, x_i.share1, Q_C);
        // Odd value plus odd Q is even, so the shift is exact
        sum_odd = {1'b0, sum} + {1'b0, Q_C};
        half    = sum[0] ? sum_odd[COEFF_W:1] : {1'b0, sum[COEFF_W-1:1]};
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_o <= '0;
        end
        else if (zeroize_i) begin
            res_o <= '0;
        end
        else begin
            res_o <= half;
        end
    end

endmodule

/* tb_ntt_masked_top.sv */
// Masked INTT stage testbench
module tb_ntt_masked_top;
    timeunit 1ns;
    timeprecision 1ps;
    import ntt_masked_pkg::*;

    localparam logic [63:0] QL       = 64'(MLDSA_Q);
    localparam coeff_t      QM1      = coeff_t'(MLDSA_Q - 1);
    localparam int          N_STIM   = 15;
    localparam bf_uv_out_t  ZERO_UV  = '0;

    typedef struct packed {
        coeff_t u00;
        coeff_t v00;
        coeff_t w00;
        coeff_t u01;
        coeff_t v01;
        coeff_t w01;
        logic   zeroize;
    } stim_t;

    typedef struct packed {
        logic [31:0] due;
        bf_uv_out_t  uv;
    } exp_t;

    // Unmasked u00, v00, w00, u01, v01, w01, zeroize
    localparam stim_t STIM [N_STIM] = '{
        // Edge values and u - v wrapping below zero
        '{23'd0, 23'd0, 23'd0, 23'd1, 23'd1, 23'd1, 1'b0},
        '{23'd1, 23'd0, 23'd1, 23'd0, 23'd1, 23'd1, 1'b0},
        '{QM1, 23'd1, 23'd2, 23'd1, QM1, QM1, 1'b0},
        '{23'd12345, 23'd678, 23'd1753, 23'd8380000, 23'd4000000, 23'd3000000, 1'b0},
        // Same entry four times with a new share split each time
        '{23'd4211, 23'd99, 23'd4808194, 23'd3, 23'd7, 23'd25847, 1'b0},
        '{23'd4211, 23'd99, 23'd4808194, 23'd3, 23'd7, 23'd25847, 1'b0},
        '{23'd4211, 23'd99, 23'd4808194, 23'd3, 23'd7, 23'd25847, 1'b0},
        '{23'd4211, 23'd99, 23'd4808194, 23'd3, 23'd7, 23'd25847, 1'b0},
        // Still in flight when the zeroize hits
        '{23'd1000000, 23'd2000000, 23'd1234567, 23'd5, 23'd6, 23'd7, 1'b0},
        '{QM1, QM1, QM1, 23'd2, 23'd3, 23'd4, 1'b0},
        '{23'd7654321, 23'd1234567, 23'd8000000, 23'd100, 23'd8380400, 23'd4, 1'b0},
        '{23'd0, 23'd0, 23'd0, 23'd0, 23'd0, 23'd0, 1'b1},
        // Normal operation again
        '{23'd2, 23'd8380415, 23'd6543210, 23'd4190208, 23'd4190209, 23'd2, 1'b0},
        '{23'd999999, 23'd3, 23'd1, 23'd77, 23'd8000000, 23'd1234, 1'b0},
        '{QM1, 23'd0, QM1, 23'd4811, 23'd4811, 23'd5555, 1'b0}
    };

    logic          clk = 1'b0;
    logic          reset_n;
    logic          zeroize_i;
    logic          valid_i;
    masked_bf_in_t uvw_i;
    logic          valid_o;
    bf_uv_out_t    uv_o;

    logic [31:0] lcg_state = 32'hb919_3e4f;
    logic [31:0] cyc       = '0;
    logic [31:0] zero_cyc  = 32'hffff_ffff;
    logic        checking  = 1'b0;
    int          value_errs = 0;
    int          valid_errs = 0;
    exp_t        exp_q [$];

    ntt_masked_top dut_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize_i(zeroize_i),
        .valid_i  (valid_i),
        .uvw_i    (uvw_i),
        .valid_o  (valid_o),
        .uv_o     (uv_o)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 32'd1;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // share0 is random and share1 makes up the rest mod Q
    function automatic masked_coeff_t split_shares(coeff_t x);
        logic [63:0]   s0;
        masked_coeff_t m;
        s0 = 64'(next_rand()) % QL;
        m.share0 = coeff_t'(s0);
        m.share1 = coeff_t'((64'(x) + QL - s0) % QL);
        return m;
    endfunction

    function automatic coeff_t halve_mod(logic [63:0] x);
        logic [63:0] h;
        if (x[0]) begin
            h = (x + QL) >> 1;
        end
        else begin
            h = x >> 1;
        end
        return coeff_t'(h);
    endfunction

    // GS butterfly on unmasked values followed by div2
    function automatic bf_uv_out_t model_stage(stim_t s);
        bf_uv_out_t r;
        r.u20 = halve_mod((64'(s.u00) + 64'(s.v00)) % QL);
        r.u21 = halve_mod(((64'(s.u00) + QL - 64'(s.v00)) % QL * 64'(s.w00)) % QL);
        r.v20 = halve_mod((64'(s.u01) + 64'(s.v01)) % QL);
        r.v21 = halve_mod(((64'(s.u01) + QL - 64'(s.v01)) % QL * 64'(s.w01)) % QL);
        return r;
    endfunction

    task automatic check_coeff(input string field, input coeff_t got, input coeff_t want);
        if (got !== want) begin
            value_errs++;
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, field, got, want);
        end
    endtask

    task automatic check_valid(input logic got, input logic want);
        if (got !== want) begin
            valid_errs++;
            $display("[ERROR] %0t ns: valid_o is %b, expected %b", $time, got, want);
        end
    endtask

    task automatic compare_outputs(input bf_uv_out_t got, input bf_uv_out_t want);
        check_coeff("u20", got.u20, want.u20);
        check_coeff("u21", got.u21, want.u21);
        check_coeff("v20", got.v20, want.v20);
        check_coeff("v21", got.v21, want.v21);
    endtask

    task automatic apply_entry(input stim_t s);
        exp_t e;
        if (s.zeroize) begin
            valid_i   = 1'b0;
            zeroize_i = 1'b1;
            uvw_i     = '0;
            // Anything not yet on the output is lost at the next edge
            while (exp_q.size() > 0 && exp_q[$].due > cyc) begin
                void'(exp_q.pop_back());
            end
            zero_cyc = cyc + 32'd1;
        end
        else begin
            valid_i   = 1'b1;
            zeroize_i = 1'b0;
            uvw_i.u00 = split_shares(s.u00);
            uvw_i.v00 = split_shares(s.v00);
            uvw_i.w00 = s.w00;
            uvw_i.u01 = split_shares(s.u01);
            uvw_i.v01 = split_shares(s.v01);
            uvw_i.w01 = s.w01;
            e.due = cyc + 32'd4;
            e.uv  = model_stage(s);
            exp_q.push_back(e);
        end
    endtask

    // Output monitor sampled mid-cycle
    always @(negedge clk) begin
        if (checking) begin
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                check_valid(valid_o, 1'b1);
                compare_outputs(uv_o, exp_q[0].uv);
                void'(exp_q.pop_front());
            end
            else begin
                check_valid(valid_o, 1'b0);
            end
            if (cyc == zero_cyc) begin
                compare_outputs(uv_o, ZERO_UV);
            end
        end
    end

    initial begin
        reset_n   = 1'b0;
        zeroize_i = 1'b0;
        valid_i   = 1'b0;
        uvw_i     = '0;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_valid(valid_o, 1'b0);
            compare_outputs(uv_o, ZERO_UV);
        end
        @(posedge clk);
        #1;
        reset_n  = 1'b1;
        checking = 1'b1;
        @(negedge clk);
        compare_outputs(uv_o, ZERO_UV);

        for (int i = 0; i < N_STIM; i++) begin
            @(posedge clk);
            #1;
            apply_entry(STIM[i]);
        end
        @(posedge clk);
        #1;
        valid_i   = 1'b0;
        zeroize_i = 1'b0;
        uvw_i     = '0;

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(posedge clk);

        $display("Value errors: %0d, valid errors: %0d", value_errs, valid_errs);
        if (value_errs == 0 && valid_errs == 0) begin
            $display("TB PASSED");
        end
        else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((N_STIM + 20) * 10);
        $display("Timeout: the run did not finish in the expected time");
        $display("TB FAILED");
        $finish;
    end

endmodule
